// ==== tb/lcd_golden.txt ====
0 0 B330 0001 07E0 F800 0000 00
0 1 9F9A 0010 07E0 FD20 0000 01
0 0 8E38 8000 07E0 FFE0 0000 02
0 0 0000 0000 07E0 2104 0000 FF
0 0 863C 0002 07E0 07E0 0000 03
0 0 7794 0004 07E0 07FF 0000 04
0 0 6A89 0100 07E0 001F 0000 05
0 0 5EE8 0200 07E0 F81F 0000 06
0 0 5993 4000 07E0 FFFF 0000 07
0 0 B330 FFFF 07E0 F800 0000 00
1 1 7794 00FF 001F 07FF 0000 FF
1 1 1234 0000 001F 0000 4208 FF
1 0 0000 0000 001F 2104 0000 FF
1 1 6A89 0000 001F 001F 8410 FF

// ==== list.f ====
src/lcd_pkg.sv
src/scene_latch.sv
src/frame_painter.sv
src/spi_byte_tx.sv
src/lcd_visualizer.sv
tb/lcd_visualizer_checker.sv
tb/tb_lcd_visualizer.sv

// ==== Makefile ====
# Verilator flow for the lcd visualizer testbench

VERILATOR ?= verilator
TB_TOP    ?= tb_lcd_visualizer
RTL_TOP   ?= lcd_visualizer
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
RTL_SRCS  ?= src/lcd_pkg.sv src/scene_latch.sv src/frame_painter.sv \
             src/spi_byte_tx.sv src/lcd_visualizer.sv
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILE_LIST) -Mdir $(BUILD_DIR)

# status comes from the pass text in the simulator output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)

// ==== tb/tb_lcd_visualizer.sv ====
//**************************************************************************
// lcd visualizer testbench
// plays the golden frames, decodes the SPI stream back into bytes and
// checks the init sequence, the window commands and every pixel
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none

module tb_lcd_visualizer import lcd_pkg::*; ();

    localparam int    FRAME_W       = 8;
    localparam int    FRAME_H       = 8;
    localparam int    HEADER_END    = 2;     // first content row
    localparam int    EFFECT_START  = 6;     // first effect row
    localparam int    MAX_FRAMES    = 32;
    localparam int    RESET_CYCLES  = 8;
    localparam int    RESET_TIMEOUT = 200;
    localparam int    BYTE_TIMEOUT  = 500;   // gap plus one byte, with margin
    localparam string GOLDEN_FILE   = "tb/lcd_golden.txt";

    typedef struct packed {
        logic        mode;
        logic        playing;
        tone_t       tone;
        logic [15:0] key_state;
        rgb565_t     header;
        rgb565_t     content;
        rgb565_t     effect_base;
        byte_t       marker;       // FF when the frame has no marker
    } frame_row_t;

    logic        clk;
    logic        rst_n;
    logic        mode;
    logic        playing;
    tone_t       tone;
    logic [15:0] key_state;
    logic        lcd_sclk;
    logic        lcd_mosi;
    logic        lcd_cs;
    logic        lcd_dc;
    logic        lcd_rst;

    frame_row_t  golden [MAX_FRAMES];
    int          frame_count;
    logic [8:0]  rx_q [$];          // {dc, data} per decoded byte
    byte_t       rx_shift;
    int          rx_bits = 0;

    lcd_visualizer #(
        .frame_width  (FRAME_W),
        .frame_height (FRAME_H)
    ) lcd_visualizer_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .mode      (mode),
        .playing   (playing),
        .tone      (tone),
        .key_state (key_state),
        .lcd_sclk  (lcd_sclk),
        .lcd_mosi  (lcd_mosi),
        .lcd_cs    (lcd_cs),
        .lcd_dc    (lcd_dc),
        .lcd_rst   (lcd_rst)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // mode 0 capture, MSB first
    always @(posedge lcd_sclk) begin
        if (!lcd_cs) begin
            rx_shift = {rx_shift[6:0], lcd_mosi};
            rx_bits  = rx_bits + 1;
            if (rx_bits == 8) begin
                rx_q.push_back({lcd_dc, rx_shift});
                rx_bits = 0;
            end
        end
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    // pin protocol assertions end the run as soon as one fails
    always @(posedge clk) begin
        if (lcd_visualizer_inst.checker_inst.fail_count != 0) begin
            stop_run("a panel pin protocol assertion failed");
        end
    end

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        if (actual !== expected) begin
            stop_run($sformatf("Fail %s expected %h got %h", name, expected, actual));
        end
    endtask

    // columns: mode playing tone key_state header content effect_base marker
    task automatic load_golden();
        int          fd;
        int          fields;
        logic [31:0] v_mode, v_playing, v_tone, v_keys;
        logic [31:0] v_header, v_content, v_effect, v_marker;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            stop_run("could not open the golden frame file");
        end
        frame_count = 0;
        fields      = 8;
        while (fields == 8 && frame_count < MAX_FRAMES) begin
            fields = $fscanf(fd, "%h %h %h %h %h %h %h %h\n", v_mode, v_playing, v_tone,
                             v_keys, v_header, v_content, v_effect, v_marker);
            if (fields == 8) begin
                golden[frame_count] = '{mode: v_mode[0], playing: v_playing[0],
                                        tone: v_tone[15:0], key_state: v_keys[15:0],
                                        header: v_header[15:0], content: v_content[15:0],
                                        effect_base: v_effect[15:0], marker: v_marker[7:0]};
                frame_count = frame_count + 1;
            end
        end
        $fclose(fd);
        if (frame_count == 0) begin
            stop_run("the golden frame file holds no frames");
        end
    endtask

    task automatic drive_inputs(input frame_row_t r);
        mode      <= r.mode;
        playing   <= r.playing;
        tone      <= r.tone;
        key_state <= r.key_state;
    endtask

    task automatic wait_panel_reset();
        int cycles;
        cycles = 0;
        while (lcd_rst !== 1'b1) begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles > RESET_TIMEOUT) begin
                stop_run("lcd_rst was never released after reset");
            end
        end
    endtask

    task automatic next_byte(output logic [8:0] item);
        int cycles;
        cycles = 0;
        while (rx_q.size() == 0) begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles > BYTE_TIMEOUT) begin
                stop_run("no SPI byte arrived from the panel interface in time");
            end
        end
        item = rx_q.pop_front();
    endtask

    task automatic expect_byte(input string what, input byte_t data, input logic dc);
        logic [8:0] item;
        next_byte(item);
        check_value({"lcd_mosi ", what}, {8'h00, data}, {8'h00, item[7:0]});
        check_value({"lcd_dc ", what}, {15'd0, dc}, {15'd0, item[8]});
    endtask

    // rows 0 and 1 header, 2 to 5 content, 6 and 7 effect
    function automatic rgb565_t expected_pixel(input frame_row_t r, input int row,
                                               input int col);
        if (row < HEADER_END) begin
            return r.header;
        end
        if (row >= EFFECT_START) begin
            if (r.marker != 8'hFF && col == int'(r.marker)) begin
                return r.content;
            end
            return r.effect_base;
        end
        return r.content;
    endfunction

    task automatic check_frame(input int f);
        frame_row_t r;
        logic [8:0] hi;
        logic [8:0] lo;
        string      where;
        r = golden[f];
        expect_byte($sformatf("frame %0d CASET", f), 8'h2A, 1'b0);
        expect_byte($sformatf("frame %0d xs hi", f), 8'h00, 1'b1);
        expect_byte($sformatf("frame %0d xs lo", f), 8'h00, 1'b1);
        expect_byte($sformatf("frame %0d xe hi", f), 8'h00, 1'b1);
        expect_byte($sformatf("frame %0d xe lo", f), 8'h07, 1'b1);
        expect_byte($sformatf("frame %0d RASET", f), 8'h2B, 1'b0);
        expect_byte($sformatf("frame %0d ys hi", f), 8'h00, 1'b1);
        expect_byte($sformatf("frame %0d ys lo", f), 8'h00, 1'b1);
        expect_byte($sformatf("frame %0d ye hi", f), 8'h00, 1'b1);
        expect_byte($sformatf("frame %0d ye lo", f), 8'h07, 1'b1);
        expect_byte($sformatf("frame %0d RAMWR", f), 8'h2C, 1'b0);
        for (int row = 0; row < FRAME_H; row++) begin
            for (int col = 0; col < FRAME_W; col++) begin
                next_byte(hi);                         // high byte first
                next_byte(lo);
                where = $sformatf("frame %0d row %0d col %0d", f, row, col);
                check_value({"lcd_mosi pixel ", where}, expected_pixel(r, row, col),
                            {hi[7:0], lo[7:0]});
                check_value({"lcd_dc pixel ", where}, 16'h0003, {14'd0, hi[8], lo[8]});
            end
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        mode      = 1'b0;
        playing   = 1'b0;
        tone      = '0;
        key_state = '0;
        load_golden();
        @(posedge clk);
        drive_inputs(golden[0]);                       // first frame set up in reset
        repeat (RESET_CYCLES - 1) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check_value("lcd_rst", 16'h0000, {15'd0, lcd_rst});
        wait_panel_reset();
        expect_byte("init SWRESET", 8'h01, 1'b0);
        expect_byte("init SLPOUT", 8'h11, 1'b0);
        expect_byte("init COLMOD", 8'h3A, 1'b0);
        expect_byte("init COLMOD arg", 8'h55, 1'b1);
        expect_byte("init DISPON", 8'h29, 1'b0);
        for (int f = 0; f < frame_count; f++) begin
            check_frame(f);
            if (f + 1 < frame_count) begin
                @(posedge clk);
                drive_inputs(golden[f + 1]);           // inside the frame gap
            end
        end
        // next frame must open right after 128 pixel bytes
        expect_byte("frame after last CASET", 8'h2A, 1'b0);
        repeat (4) @(posedge clk);
        if (lcd_visualizer_inst.checker_inst.fail_count != 0) begin
            stop_run("panel pin protocol assertions failed during the run");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== tb/lcd_visualizer_checker.sv ====
//**************************************************************************
// panel pin protocol checker
// bound into the visualizer top, watches sclk, cs, dc and lcd_rst
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none

module lcd_visualizer_checker (
    input logic clk,
    input logic rst_n,
    input logic lcd_sclk,
    input logic lcd_cs,
    input logic lcd_dc,
    input logic lcd_rst
);

    int unsigned sclk_errors = 0;
    int unsigned dc_errors   = 0;
    int unsigned rst_errors  = 0;
    int unsigned fail_count;

    assign fail_count = sclk_errors + dc_errors + rst_errors;

    sclk_idle_low: assert property (@(posedge clk) disable iff (!rst_n)
        lcd_cs |-> !lcd_sclk)
        else begin
            $error("lcd_sclk high while lcd_cs is high");
            sclk_errors++;
        end

    // dc is fixed for the whole byte
    dc_stable_in_byte: assert property (@(posedge clk) disable iff (!rst_n)
        (!lcd_cs && !$past(lcd_cs)) |-> $stable(lcd_dc))
        else begin
            $error("lcd_dc changed while lcd_cs stayed low");
            dc_errors++;
        end

    cs_idle_in_reset: assert property (@(posedge clk) disable iff (!rst_n)
        !lcd_rst |-> lcd_cs)
        else begin
            $error("lcd_cs low while the panel is held in reset");
            rst_errors++;
        end

endmodule

bind lcd_visualizer lcd_visualizer_checker checker_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .lcd_sclk (lcd_sclk),
    .lcd_cs   (lcd_cs),
    .lcd_dc   (lcd_dc),
    .lcd_rst  (lcd_rst)
);

`default_nettype wire

// ==== src/lcd_visualizer.sv ====
//**************************************************************************
// lcd visualizer top
// player state in, ST7789 SPI panel pins out
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none

module lcd_visualizer import lcd_pkg::*; #(
    parameter int frame_width  = LCD_WIDTH,
    parameter int frame_height = LCD_HEIGHT
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        mode,
    input  logic        playing,
    input  tone_t       tone,
    input  logic [15:0] key_state,
    output logic        lcd_sclk,
    output logic        lcd_mosi,
    output logic        lcd_cs,
    output logic        lcd_dc,
    output logic        lcd_rst
);

    scene_t   scene;
    spi_req_t spi_req;
    logic     frame_start;
    logic     tx_start;
    logic     tx_ready;

    scene_latch scene_latch_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .frame_start (frame_start),
        .mode        (mode),
        .playing     (playing),
        .tone        (tone),
        .key_state   (key_state),
        .scene       (scene)
    );

    frame_painter #(
        .frame_width  (frame_width),
        .frame_height (frame_height)
    ) frame_painter_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .scene       (scene),
        .tx_ready    (tx_ready),
        .frame_start (frame_start),
        .spi_req     (spi_req),
        .tx_start    (tx_start),
        .lcd_rst     (lcd_rst)
    );

    spi_byte_tx spi_byte_tx_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .spi_req  (spi_req),
        .tx_start (tx_start),
        .tx_ready (tx_ready),
        .sclk     (lcd_sclk),
        .mosi     (lcd_mosi),
        .cs       (lcd_cs),
        .dc       (lcd_dc)
    );

endmodule

`default_nettype wire

// ==== src/spi_byte_tx.sv ====
//**************************************************************************
// spi byte transmitter
// mode 0 serializer, MSB first, with chip select and data/command
// held for the whole byte and a start/ready handshake
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none

module spi_byte_tx import lcd_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  spi_req_t spi_req,
    input  logic     tx_start,
    output logic     tx_ready,
    output logic     sclk,
    output logic     mosi,
    output logic     cs,
    output logic     dc
);

    logic [DIV_W-1:0] div_cnt;
    logic [4:0]       half_cnt;    // sclk edges so far, 16 per byte
    byte_t            shreg;
    logic             accept;
    logic             toggle;

    assign accept = tx_start && tx_ready;
    assign toggle = !tx_ready && (half_cnt != 5'd16)
                    && (div_cnt == DIV_W'(SPI_DIV - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_ready <= 1'b1;
            cs       <= 1'b1;
            sclk     <= 1'b0;
            mosi     <= 1'b0;
            dc       <= 1'b0;
            div_cnt  <= '0;
            half_cnt <= '0;
        end else if (accept) begin
            tx_ready <= 1'b0;
            cs       <= 1'b0;
            dc       <= spi_req.dc;
            mosi     <= spi_req.data[7];     // first bit ready before first rise
            div_cnt  <= '0;
            half_cnt <= '0;
        end else if (!tx_ready) begin
            if (half_cnt == 5'd16) begin
                tx_ready <= 1'b1;            // one cycle after last fall
                cs       <= 1'b1;
            end else if (toggle) begin
                div_cnt  <= '0;
                sclk     <= !sclk;
                half_cnt <= half_cnt + 5'd1;
                if (sclk) begin
                    mosi <= shreg[6];        // shift on falling edge
                end
            end else begin
                div_cnt <= div_cnt + DIV_W'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            shreg <= spi_req.data;
        end else if (toggle && sclk) begin
            shreg <= {shreg[6:0], 1'b0};
        end
    end

endmodule

`default_nettype wire

// ==== src/frame_painter.sv ====
//**************************************************************************
// frame painter
// panel reset and init, then an endless loop of window setup and a
// row-major raster of three colour bands with a per-frame effect
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none

module frame_painter import lcd_pkg::*; #(
    parameter int frame_width  = LCD_WIDTH,
    parameter int frame_height = LCD_HEIGHT
) (
    input  logic     clk,
    input  logic     rst_n,
    input  scene_t   scene,
    input  logic     tx_ready,
    output logic     frame_start,
    output spi_req_t spi_req,
    output logic     tx_start,
    output logic     lcd_rst
);

    typedef enum logic [2:0] {
        st_rst_hold,
        st_rst_wait,
        st_init,
        st_frame_start,
        st_window,
        st_ramwr,
        st_pixels,
        st_gap
    } paint_state_e;

    paint_state_e state;
    logic [6:0]   wait_cnt;     // reset hold, reset wait and gap
    logic [3:0]   idx;          // byte index in init and window
    coord_t       col;
    coord_t       row;
    logic         byte_hi;      // next pixel byte is the high one
    coord_t       flow_pos;
    byte_t        breath_phase;
    byte_t        breath_level;
    rgb565_t      breath_color;
    rgb565_t      pixel_color;
    logic         sending;
    logic         last_pixel;

    // triangle wave, twice the phase going up and back down
    assign breath_level = breath_phase[7] ? {~breath_phase[6:0], 1'b0}
                                          : {breath_phase[6:0], 1'b0};
    assign breath_color = {breath_level[7:3], breath_level[7:2], breath_level[7:3]};

    always_comb begin
        if (row < coord_t'(frame_height / 4)) begin
            pixel_color = scene.header_color;
        end else if (row >= coord_t'(frame_height - frame_height / 4)) begin
            case (scene.effect)
                effect_flow:   pixel_color = (col == flow_pos) ? scene.content_color
                                                               : COLOR_BLACK;
                effect_breath: pixel_color = breath_color;
                default:       pixel_color = COLOR_BLACK;
            endcase
        end else begin
            pixel_color = scene.content_color;
        end
    end

    always_comb begin
        sending = 1'b0;
        spi_req = '{data: 8'h00, dc: 1'b0};
        case (state)
            st_init: begin
                sending = 1'b1;
                case (idx)
                    4'd0:    spi_req = '{data: CMD_SWRESET, dc: 1'b0};
                    4'd1:    spi_req = '{data: CMD_SLPOUT, dc: 1'b0};
                    4'd2:    spi_req = '{data: CMD_COLMOD, dc: 1'b0};
                    4'd3:    spi_req = '{data: COLMOD_ARG, dc: 1'b1};
                    default: spi_req = '{data: CMD_DISPON, dc: 1'b0};
                endcase
            end
            st_window: begin
                sending = 1'b1;
                case (idx)
                    4'd0:    spi_req = '{data: CMD_CASET, dc: 1'b0};
                    4'd3:    spi_req = '{data: byte_t'((frame_width - 1) >> 8), dc: 1'b1};
                    4'd4:    spi_req = '{data: byte_t'(frame_width - 1), dc: 1'b1};
                    4'd5:    spi_req = '{data: CMD_RASET, dc: 1'b0};
                    4'd8:    spi_req = '{data: byte_t'((frame_height - 1) >> 8), dc: 1'b1};
                    4'd9:    spi_req = '{data: byte_t'(frame_height - 1), dc: 1'b1};
                    default: spi_req = '{data: 8'h00, dc: 1'b1}; // start address
                endcase
            end
            st_ramwr: begin
                sending = 1'b1;
                spi_req = '{data: CMD_RAMWR, dc: 1'b0};
            end
            st_pixels: begin
                sending = 1'b1;
                spi_req = '{data: byte_hi ? pixel_color[15:8] : pixel_color[7:0], dc: 1'b1};
            end
            default: ;
        endcase
    end

    assign tx_start    = sending && tx_ready;
    assign frame_start = (state == st_frame_start);
    assign last_pixel  = !byte_hi && (col == coord_t'(frame_width - 1))
                         && (row == coord_t'(frame_height - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= st_rst_hold;
            wait_cnt     <= '0;
            idx          <= '0;
            col          <= '0;
            row          <= '0;
            byte_hi      <= 1'b1;
            flow_pos     <= '0;
            breath_phase <= '0;
            lcd_rst      <= 1'b0;
        end else begin
            case (state)
                st_rst_hold: begin
                    if (wait_cnt == 7'(RESET_HOLD - 1)) begin
                        wait_cnt <= '0;
                        lcd_rst  <= 1'b1;        // release panel reset
                        state    <= st_rst_wait;
                    end else begin
                        wait_cnt <= wait_cnt + 7'd1;
                    end
                end
                st_rst_wait: begin
                    if (wait_cnt == 7'(RESET_WAIT - 1)) begin
                        wait_cnt <= '0;
                        idx      <= '0;
                        state    <= st_init;
                    end else begin
                        wait_cnt <= wait_cnt + 7'd1;
                    end
                end
                st_init: begin
                    if (tx_start) begin
                        if (idx == 4'd4) begin
                            state <= st_frame_start;
                        end else begin
                            idx <= idx + 4'd1;
                        end
                    end
                end
                st_frame_start: begin
                    idx   <= '0;
                    state <= st_window;
                end
                st_window: begin
                    if (tx_start) begin
                        if (idx == 4'd9) begin
                            state <= st_ramwr;
                        end else begin
                            idx <= idx + 4'd1;
                        end
                    end
                end
                st_ramwr: begin
                    if (tx_start) begin
                        col     <= '0;
                        row     <= '0;
                        byte_hi <= 1'b1;
                        state   <= st_pixels;
                    end
                end
                st_pixels: begin
                    if (tx_start) begin
                        byte_hi <= !byte_hi;
                        if (!byte_hi) begin              // low byte ends the pixel
                            if (col == coord_t'(frame_width - 1)) begin
                                col <= '0;
                                row <= row + coord_t'(1);
                            end else begin
                                col <= col + coord_t'(1);
                            end
                        end
                        if (last_pixel) begin
                            wait_cnt <= '0;
                            state    <= st_gap;
                            // effects step once per frame of their own kind
                            case (scene.effect)
                                effect_flow: begin
                                    flow_pos <= (flow_pos == coord_t'(frame_width - 1))
                                                ? '0 : flow_pos + coord_t'(1);
                                end
                                effect_breath: begin
                                    breath_phase <= breath_phase + byte_t'(BREATH_STEP);
                                end
                                default: ;
                            endcase
                        end
                    end
                end
                st_gap: begin
                    if (tx_ready) begin                  // last byte has finished
                        if (wait_cnt == 7'(FRAME_GAP - 1)) begin
                            wait_cnt <= '0;
                            state    <= st_frame_start;
                        end else begin
                            wait_cnt <= wait_cnt + 7'd1;
                        end
                    end
                end
                default: state <= st_rst_hold;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/scene_latch.sv ====
//**************************************************************************
// scene latch
// samples the player state at frame start and turns it into the band
// colours and the effect kind used for the whole frame
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none

module scene_latch import lcd_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        frame_start,
    input  logic        mode,        // 0 manual, 1 automatic
    input  logic        playing,
    input  tone_t       tone,
    input  logic [15:0] key_state,
    output scene_t      scene
);

    rgb565_t tone_color;
    rgb565_t header_next;
    effect_e effect_next;

    always_comb begin
        case (tone)
            16'd0:   tone_color = COLOR_IDLE_TONE;  // silence
            TONE_C4: tone_color = COLOR_C4;
            TONE_D4: tone_color = COLOR_D4;
            TONE_E4: tone_color = COLOR_E4;
            TONE_F4: tone_color = COLOR_F4;
            TONE_G4: tone_color = COLOR_G4;
            TONE_A4: tone_color = COLOR_A4;
            TONE_B4: tone_color = COLOR_B4;
            TONE_C5: tone_color = COLOR_C5;
            default: tone_color = COLOR_UNKNOWN_TONE;
        endcase
    end

    assign header_next = mode ? COLOR_AUTO : COLOR_MANUAL;

    always_comb begin
        if (!mode && (|key_state)) begin
            effect_next = effect_flow;        // manual, key held
        end else if (mode && playing) begin
            effect_next = effect_breath;      // auto play
        end else begin
            effect_next = effect_off;
        end
    end

    // scene stays fixed from one frame_start to the next
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            scene <= '{header_color:  COLOR_BLACK,
                       content_color: COLOR_BLACK,
                       effect:        effect_off};
        end else if (frame_start) begin
            scene <= '{header_color:  header_next,
                       content_color: tone_color,
                       effect:        effect_next};
        end
    end

endmodule

`default_nettype wire

// ==== src/lcd_pkg.sv ====
//**************************************************************************
// lcd visualizer shared definitions
// pixel and byte types, scene record, RGB565 colours, ST7789 commands
// and the timing constants of the panel driver
//**************************************************************************
`default_nettype none

package lcd_pkg;

    typedef logic [7:0]  byte_t;      // spi payload byte
    typedef logic [15:0] rgb565_t;    // 5:6:5 pixel
    typedef logic [15:0] tone_t;      // divider value from the player
    typedef logic [8:0]  coord_t;     // column or row index

    typedef enum logic [1:0] {
        effect_off,
        effect_flow,
        effect_breath
    } effect_e;

    typedef struct packed {
        rgb565_t header_color;
        rgb565_t content_color;
        effect_e effect;
    } scene_t;

    typedef struct packed {
        byte_t data;
        logic  dc;                    // 1 data, 0 command
    } spi_req_t;

    localparam rgb565_t COLOR_BLACK        = 16'h0000;
    localparam rgb565_t COLOR_MANUAL       = 16'h07E0; // green
    localparam rgb565_t COLOR_AUTO         = 16'h001F; // blue
    localparam rgb565_t COLOR_IDLE_TONE    = 16'h2104; // dark grey, tone is zero
    localparam rgb565_t COLOR_UNKNOWN_TONE = 16'h0000;

    // tone dividers of the player, C4 up to C5
    localparam tone_t TONE_C4 = 16'd45872;
    localparam tone_t TONE_D4 = 16'd40858;
    localparam tone_t TONE_E4 = 16'd36408;
    localparam tone_t TONE_F4 = 16'd34364;
    localparam tone_t TONE_G4 = 16'd30612;
    localparam tone_t TONE_A4 = 16'd27273;
    localparam tone_t TONE_B4 = 16'd24296;
    localparam tone_t TONE_C5 = 16'd22931;

    localparam rgb565_t COLOR_C4 = 16'hF800; // red
    localparam rgb565_t COLOR_D4 = 16'hFD20; // orange
    localparam rgb565_t COLOR_E4 = 16'hFFE0; // yellow
    localparam rgb565_t COLOR_F4 = 16'h07E0; // green
    localparam rgb565_t COLOR_G4 = 16'h07FF; // cyan
    localparam rgb565_t COLOR_A4 = 16'h001F; // blue
    localparam rgb565_t COLOR_B4 = 16'hF81F; // purple
    localparam rgb565_t COLOR_C5 = 16'hFFFF; // white

    localparam byte_t CMD_SWRESET = 8'h01;
    localparam byte_t CMD_SLPOUT  = 8'h11;
    localparam byte_t CMD_COLMOD  = 8'h3A;
    localparam byte_t COLMOD_ARG  = 8'h55; // 16 bit per pixel
    localparam byte_t CMD_DISPON  = 8'h29;
    localparam byte_t CMD_CASET   = 8'h2A;
    localparam byte_t CMD_RASET   = 8'h2B;
    localparam byte_t CMD_RAMWR   = 8'h2C;

    localparam int SPI_DIV     = 2;   // clk cycles per sclk half period
    localparam int DIV_W       = (SPI_DIV > 1) ? $clog2(SPI_DIV) : 1;
    localparam int RESET_HOLD  = 16;  // lcd_rst low
    localparam int RESET_WAIT  = 32;  // settle after release
    localparam int FRAME_GAP   = 64;  // idle between frames
    localparam int BREATH_STEP = 32;  // phase step per breath frame

    localparam int LCD_WIDTH  = 240;
    localparam int LCD_HEIGHT = 320;

endpackage

`default_nettype wire
